/* rtl/rvExecPkg.sv */
`default_nettype none

package rvExecPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [1:0]  aluOp_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [7:0]  apbAddr_t;

    typedef enum logic [3:0] {
        aluNone, aluAdd, aluSub, aluSubUnsigned, aluAnd, aluOr, aluXor,
        aluShiftL, aluShiftR, aluShiftRArith, aluLessSigned, aluLessUnsigned
    } aluCtrl_t;

    // Instruction class carried from decode to the ALU
    localparam aluOp_t classAddr   = 2'b00;
    localparam aluOp_t classBranch = 2'b01;
    localparam aluOp_t classReg    = 2'b10;
    localparam aluOp_t classImm    = 2'b11;

    // Major opcodes
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // APB register map
    localparam apbAddr_t addrInstr  = 8'h00; // Write only
    localparam apbAddr_t addrStatus = 8'h04;
    localparam apbAddr_t addrResult = 8'h08;
    localparam apbAddr_t addrBranch = 8'h0C;

endpackage

`default_nettype wire

/* rtl/instrDecode.sv */
`default_nettype none

module instrDecode import rvExecPkg::*; (
    input  word_t   instr,
    output aluOp_t  aluOp,
    output logic    aluSrc,    // 1 selects the immediate
    output funct3_t funct3,
    output funct7_t funct7,
    output word_t   imm32,
    output regIdx_t rs1,
    output regIdx_t rs2,
    output regIdx_t rd,
    output logic    writeEn,
    output logic    isBranch,
    output logic    illegal
);

    logic [6:0] opcode;
    word_t      immI, immB;

    // ----------------------------------------------------------
    // Fixed instruction fields
    // ----------------------------------------------------------
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        aluOp    = classAddr;
        aluSrc   = 1'b0;
        imm32    = immI;
        isBranch = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            opOp: aluOp = classReg;
            opOpImm: begin
                aluOp  = classImm;
                aluSrc = 1'b1;
            end
            opBranch: begin
                aluOp    = classBranch;
                imm32    = immB;  // Offset only, no PC here
                isBranch = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // Branches, illegal words and x0 destinations never write back
    assign writeEn = ((aluOp == classReg) || (aluOp == classImm)) && (rd != '0);

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu import rvExecPkg::*; (
    input  word_t   readData1,
    input  word_t   readData2,
    input  word_t   imm32,
    input  logic    aluSrc,
    input  aluOp_t  aluOp,
    input  funct3_t funct3,
    input  funct7_t funct7,
    output word_t   aluResult,
    output logic    zero       // Taken flag for branches
);

    // OP and OP-IMM funct3
    localparam funct3_t f3AddSub = 3'b000;
    localparam funct3_t f3Sll    = 3'b001;
    localparam funct3_t f3Slt    = 3'b010;
    localparam funct3_t f3Sltu   = 3'b011;
    localparam funct3_t f3Xor    = 3'b100;
    localparam funct3_t f3Srl    = 3'b101;
    localparam funct3_t f3Or     = 3'b110;
    localparam funct3_t f3And    = 3'b111;
    // BRANCH funct3
    localparam funct3_t f3Beq  = 3'b000;
    localparam funct3_t f3Bne  = 3'b001;
    localparam funct3_t f3Blt  = 3'b100;
    localparam funct3_t f3Bge  = 3'b101;
    localparam funct3_t f3Bltu = 3'b110;
    localparam funct3_t f3Bgeu = 3'b111;

    localparam funct7_t f7Base = 7'b0000000;
    localparam funct7_t f7Alt  = 7'b0100000;  // SUB and SRA

    aluCtrl_t   aluCtrl;
    word_t      operand1, operand2;
    logic [4:0] shamt;
    logic       lessSigned, lessUnsigned;

    assign operand1     = readData1;
    assign operand2     = aluSrc ? imm32 : readData2;
    assign shamt        = operand2[4:0];
    assign lessSigned   = $signed(operand1) < $signed(operand2);
    assign lessUnsigned = operand1 < operand2;

    // ----------------------------------------------------------
    // Class and funct fields to ALU control
    // ----------------------------------------------------------
    always_comb begin
        aluCtrl = aluNone;
        case (aluOp)
            classAddr:   aluCtrl = aluAdd;
            classBranch: aluCtrl = ((funct3 == f3Bltu) || (funct3 == f3Bgeu)) ?
                                   aluSubUnsigned : aluSub;
            classReg: begin
                case ({funct7, funct3})
                    {f7Base, f3AddSub}: aluCtrl = aluAdd;
                    {f7Alt,  f3AddSub}: aluCtrl = aluSub;
                    {f7Base, f3Xor}:    aluCtrl = aluXor;
                    {f7Base, f3Or}:     aluCtrl = aluOr;
                    {f7Base, f3And}:    aluCtrl = aluAnd;
                    {f7Base, f3Sll}:    aluCtrl = aluShiftL;
                    {f7Base, f3Srl}:    aluCtrl = aluShiftR;
                    {f7Alt,  f3Srl}:    aluCtrl = aluShiftRArith;
                    {f7Base, f3Slt}:    aluCtrl = aluLessSigned;
                    {f7Base, f3Sltu}:   aluCtrl = aluLessUnsigned;
                    default:            aluCtrl = aluNone;
                endcase
            end
            classImm: begin
                case (funct3)
                    f3AddSub: aluCtrl = aluAdd;
                    f3Xor:    aluCtrl = aluXor;
                    f3Or:     aluCtrl = aluOr;
                    f3And:    aluCtrl = aluAnd;
                    f3Sll:    aluCtrl = aluShiftL;
                    f3Srl:    aluCtrl = (funct7 == f7Alt) ? aluShiftRArith : aluShiftR;
                    f3Slt:    aluCtrl = aluLessSigned;
                    f3Sltu:   aluCtrl = aluLessUnsigned;
                    default:  aluCtrl = aluNone;
                endcase
            end
            default: aluCtrl = aluNone;
        endcase
    end

    always_comb begin
        case (aluCtrl)
            aluAdd:          aluResult = operand1 + operand2;
            aluSub:          aluResult = operand1 - operand2;
            aluSubUnsigned:  aluResult = operand1 - operand2;
            aluAnd:          aluResult = operand1 & operand2;
            aluOr:           aluResult = operand1 | operand2;
            aluXor:          aluResult = operand1 ^ operand2;
            aluShiftL:       aluResult = operand1 << shamt;
            aluShiftR:       aluResult = operand1 >> shamt;
            aluShiftRArith:  aluResult = $signed(operand1) >>> shamt;
            aluLessSigned:   aluResult = {31'b0, lessSigned};
            aluLessUnsigned: aluResult = {31'b0, lessUnsigned};
            default:         aluResult = '0;
        endcase
    end

    // Branch condition from the compares, not the difference sign
    always_comb begin
        if (aluOp == classBranch) begin
            case (funct3)
                f3Beq:   zero = (aluResult == '0);
                f3Bne:   zero = (aluResult != '0);
                f3Blt:   zero = lessSigned;
                f3Bge:   zero = !lessSigned;
                f3Bltu:  zero = lessUnsigned;
                f3Bgeu:  zero = !lessUnsigned;
                default: zero = 1'b0;
            endcase
        end else begin
            zero = (aluResult == '0);
        end
    end

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`default_nettype none

module execUnit import rvExecPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       popValid,
    input  word_t      popData,
    output logic       popReady,
    output logic       busyExec,
    output word_t      lastResult,
    output logic       branchTaken,
    output logic [7:0] branchCount,
    output logic [7:0] illegalCount
);

    aluOp_t  decAluOp, s1AluOp;
    logic    decAluSrc, decWriteEn, decIsBranch, decIllegal, s1AluSrc;
    funct3_t decFunct3, s1Funct3;
    funct7_t decFunct7, s1Funct7;
    word_t   decImm, s1Imm, s1Op1, s1Op2, fwdOp1, fwdOp2, aluResult;
    regIdx_t decRs1, decRs2, decRd, s1Rd;
    logic    s1Valid, s1WriteEn, s1IsBranch, s1Illegal, aluZero, take;
    word_t   regFile [32];

    assign popReady = 1'b1;  // Never stalls
    assign take     = popValid && popReady;
    assign busyExec = s1Valid;

    instrDecode decode0 (.instr(popData), .aluOp(decAluOp), .aluSrc(decAluSrc),
        .funct3(decFunct3), .funct7(decFunct7), .imm32(decImm), .rs1(decRs1),
        .rs2(decRs2), .rd(decRd), .writeEn(decWriteEn), .isBranch(decIsBranch),
        .illegal(decIllegal));

    // Operand read, stage-2 result bypasses the register file
    always_comb begin
        fwdOp1 = (decRs1 == '0) ? '0 : regFile[decRs1];
        fwdOp2 = (decRs2 == '0) ? '0 : regFile[decRs2];
        if (s1WriteEn && (s1Rd == decRs1)) fwdOp1 = aluResult;
        if (s1WriteEn && (s1Rd == decRs2)) fwdOp2 = aluResult;
    end

    // ----------------------------------------------------------
    // Stage 1
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            s1Valid    <= 1'b0;
            s1WriteEn  <= 1'b0;
            s1IsBranch <= 1'b0;
            s1Illegal  <= 1'b0;
        end else begin
            s1Valid    <= take;
            s1WriteEn  <= take && decWriteEn;
            s1IsBranch <= take && decIsBranch;
            s1Illegal  <= take && decIllegal;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            {s1AluOp, s1AluSrc, s1Funct3, s1Funct7} <= {decAluOp, decAluSrc, decFunct3, decFunct7};
            {s1Imm, s1Op1, s1Op2, s1Rd} <= {decImm, fwdOp1, fwdOp2, decRd};
        end
    end

    // ----------------------------------------------------------
    // Stage 2, execute and writeback
    // ----------------------------------------------------------
    alu alu0 (.readData1(s1Op1), .readData2(s1Op2), .imm32(s1Imm), .aluSrc(s1AluSrc),
        .aluOp(s1AluOp), .funct3(s1Funct3), .funct7(s1Funct7), .aluResult(aluResult),
        .zero(aluZero));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) regFile[i] <= '0;
            lastResult   <= '0;
            branchTaken  <= 1'b0;
            branchCount  <= '0;
            illegalCount <= '0;
        end else begin
            if (s1WriteEn) begin  // Never x0
                regFile[s1Rd] <= aluResult;
                lastResult    <= aluResult;
            end
            if (s1IsBranch) begin
                branchTaken <= aluZero;
                if (aluZero) branchCount <= branchCount + 8'd1;
            end
            if (s1Illegal) illegalCount <= illegalCount + 8'd1;
        end
    end

endmodule

`default_nettype wire

/* rtl/instrQueue.sv */
`default_nettype none

module instrQueue import rvExecPkg::*; #(
    parameter int Depth = 4  // Power of two
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pushValid,
    input  word_t                   pushData,
    input  logic                    popReady,
    output logic                    full,
    output logic                    popValid,
    output word_t                   popData,
    output logic [$clog2(Depth):0]  level
);

    localparam int PtrW = $clog2(Depth);

    word_t           mem [Depth];
    logic [PtrW-1:0] wrPtr, rdPtr;
    logic            doPush, doPop;

    assign full     = (level == Depth);
    assign popValid = (level != '0);
    assign popData  = mem[rdPtr];
    assign doPush   = pushValid && !full;
    assign doPop    = popValid && popReady;

    always_ff @(posedge clk) begin
        if (doPush) mem[wrPtr] <= pushData;
    end

    // Pointers wrap on their own since Depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            level <= '0;
        end else begin
            if (doPush) wrPtr <= wrPtr + 1'b1;
            if (doPop)  rdPtr <= rdPtr + 1'b1;
            level <= level + doPush - doPop;
        end
    end

endmodule

`default_nettype wire

/* rtl/apbCmdPort.sv */
`default_nettype none

module apbCmdPort import rvExecPkg::*; #(
    parameter int QueueDepth = 4
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  apbAddr_t                     paddr,
    input  word_t                        pwdata,
    input  logic                         full,
    input  logic [$clog2(QueueDepth):0]  level,
    input  logic                         busyExec,
    input  word_t                        lastResult,
    input  logic                         branchTaken,
    input  logic [7:0]                   branchCount,
    input  logic [7:0]                   illegalCount,
    output word_t                        prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         pushValid,
    output word_t                        pushData
);

    logic  setup, access, instrWrite, addrOk, busy;
    word_t statusWord, readMux;

    assign setup      = psel && !penable;
    assign access     = psel && penable;
    assign instrWrite = access && pwrite && (paddr == addrInstr);

    // Back-pressure: hold the write until the queue has room
    assign pready    = !(instrWrite && full);
    assign pushValid = instrWrite && !full;
    assign pushData  = pwdata;

    assign busy       = (level != '0) || busyExec || pushValid;
    assign statusWord = {8'h00, 8'(level), illegalCount, 7'b0, busy};

    always_comb begin
        addrOk = (paddr == addrInstr) || (paddr == addrStatus) ||
                 (paddr == addrResult) || (paddr == addrBranch);
        case (paddr)
            addrStatus: readMux = statusWord;
            addrResult: readMux = lastResult;
            addrBranch: readMux = {16'h0000, branchCount, 7'b0, branchTaken};
            default:    readMux = '0;  // INSTR reads back zero
        endcase
    end

    // Read data and error captured in the setup phase
    always_ff @(posedge clk) begin
        if (reset) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup) begin
            prdata  <= pwrite ? '0 : readMux;
            pslverr <= !addrOk;
        end else if (access && pready) begin
            pslverr <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/rvExecTop.sv */
`default_nettype none

module rvExecTop import rvExecPkg::*; #(
    parameter int QueueDepth = 4
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  apbAddr_t paddr,
    input  word_t    pwdata,
    output word_t    prdata,
    output logic     pready,
    output logic     pslverr
);

    logic                        pushValid, full, popValid, popReady, busyExec, branchTaken;
    word_t                       pushData, popData, lastResult;
    logic [$clog2(QueueDepth):0] level;
    logic [7:0]                  branchCount, illegalCount;

    // Producer, buffer and consumer
    apbCmdPort #(.QueueDepth(QueueDepth)) port0 (.clk, .reset, .psel, .penable, .pwrite,
        .paddr, .pwdata, .full, .level, .busyExec, .lastResult, .branchTaken, .branchCount,
        .illegalCount, .prdata, .pready, .pslverr, .pushValid, .pushData);

    instrQueue #(.Depth(QueueDepth)) queue0 (.clk, .reset, .pushValid, .pushData,
        .popReady, .full, .popValid, .popData, .level);

    execUnit exec0 (.clk, .reset, .popValid, .popData, .popReady, .busyExec, .lastResult,
        .branchTaken, .branchCount, .illegalCount);

endmodule

`default_nettype wire

/* bench/execUnit_assert.sv */
`default_nettype none

module execUnitAssert import rvExecPkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       popValid,
    input logic       busyExec,
    input regIdx_t    decRs1,
    input word_t      fwdOp1,
    input word_t      x0,
    input logic [7:0] branchCount
);

    // A popped word always reaches stage 1
    popAccepted: assert property (@(posedge clk) disable iff (reset) popValid |=> busyExec)
        else $error("popped word missed stage 1, execute unit stalled");

    // x0 stays zero in storage and on the operand path
    x0Storage: assert property (@(posedge clk) disable iff (reset) x0 == '0)
        else $error("register x0 holds a nonzero value");
    x0Operand: assert property (@(posedge clk) disable iff (reset) decRs1 == '0 |-> fwdOp1 == '0)
        else $error("operand read from x0 is nonzero");

    branchCountUp: assert property (@(posedge clk) disable iff (reset)
        branchCount >= $past(branchCount))
        else $error("branch count decreased");

endmodule

bind execUnit execUnitAssert assert0 (.clk, .reset, .popValid, .busyExec, .decRs1, .fwdOp1,
    .x0(regFile[0]), .branchCount);

`default_nettype wire

/* bench/rvExecBench.sv */
`default_nettype none

module rvExecBench import rvExecPkg::*; ();

    localparam int         QueueDepth = 4;
    localparam logic [6:0] opLoad     = 7'b0000011;
    localparam apbAddr_t   addrBad    = 8'h20;
    // About 90 instructions with a few status and result reads each
    localparam int         MaxCycles  = 90 * 24 + 100;

    localparam funct3_t immF3 [9]  = '{3'd0, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
    localparam funct3_t regF3 [10] = '{3'd0, 3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5, 3'd2,
                                       3'd3};
    localparam funct3_t brF3 [6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic     clk = 1'b0;
    logic     reset, psel, penable, pwrite, pready, pslverr;
    apbAddr_t paddr;
    word_t    pwdata, prdata;

    word_t      refReg [32];   // Reference register file
    word_t      expResult;
    logic       expTaken;
    logic [7:0] expBranchCount, expIllegal;
    int         errors = 0;
    int         checks = 0;
    int         testStart = 0;
    int         cycles = 0;
    integer     seed = 32'h5e5e1f3a;

    rvExecTop #(.QueueDepth(QueueDepth)) dut0 (.clk, .reset, .psel, .penable, .pwrite,
        .paddr, .pwdata, .prdata, .pready, .pslverr);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MaxCycles) begin
            $display("Timeout after %0d cycles, the DUT never returned to idle", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ----------------------------------------------------------
    // Encoders and reference model
    // ----------------------------------------------------------
    function automatic word_t rTypeWord(funct7_t f7, regIdx_t rs2, regIdx_t rs1, funct3_t f3,
                                        regIdx_t rd);
        return {f7, rs2, rs1, f3, rd, opOp};
    endfunction

    function automatic word_t iTypeWord(logic [11:0] imm, regIdx_t rs1, funct3_t f3, regIdx_t rd);
        return {imm, rs1, f3, rd, opOpImm};
    endfunction

    function automatic word_t branchWord(logic [12:0] off, regIdx_t rs2, regIdx_t rs1, funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic word_t opResult(funct3_t f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return word_t'($signed(a) < $signed(b));
            3'd3:    return word_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRule(funct3_t f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            3'd7:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic modelStep(word_t instr);
        logic [6:0] op;
        word_t      a, b, res;
        op = instr[6:0];
        a  = refReg[instr[19:15]];
        b  = (op == opOpImm) ? {{20{instr[31]}}, instr[31:20]} : refReg[instr[24:20]];
        if (op == opOp || op == opOpImm) begin
            // Bit 30 selects SUB, SRA and SRAI only
            res = opResult(instr[14:12], instr[30] && (op == opOp || instr[14:12] == 3'd5), a, b);
            if (instr[11:7] != 5'd0) begin
                refReg[instr[11:7]] = res;
                expResult = res;
            end
        end else if (op == opBranch) begin
            expTaken = branchRule(instr[14:12], a, b);
            if (expTaken) expBranchCount++;
        end else begin
            expIllegal++;
        end
    endtask

    // ----------------------------------------------------------
    // APB access and checks
    // ----------------------------------------------------------
    task automatic apbAccess(logic write, apbAddr_t addr, word_t wdata, output word_t rdata,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin  // Wait states
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
    endtask

    task automatic apbWrite(apbAddr_t addr, word_t data, output logic err);
        word_t unused;
        apbAccess(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(apbAddr_t addr, output word_t data, output logic err);
        apbAccess(1'b0, addr, '0, data, err);
    endtask

    task automatic busIdle();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, bit got, bit exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic issue(word_t instr);
        logic err;
        apbWrite(addrInstr, instr, err);
        checkFlag("pslverr", err, 1'b0);
        modelStep(instr);
    endtask

    task automatic waitIdle();  // Polls busy in STATUS
        word_t status;
        logic  err;
        do begin
            apbRead(addrStatus, status, err);
        end while (status[0]);
        busIdle();
    endtask

    task automatic compareResult();
        word_t data;
        logic  err;
        apbRead(addrResult, data, err);
        checkWord("RESULT", data, expResult);
    endtask

    task automatic compareBranch();
        word_t data;
        logic  err;
        apbRead(addrBranch, data, err);
        checkFlag("branchTaken", data[0], expTaken);
        checkWord("branchCount", word_t'(data[15:8]), word_t'(expBranchCount));
    endtask

    task automatic runAndCheck(word_t instr);
        issue(instr);
        waitIdle();
        compareResult();
    endtask

    task automatic endTest(string name);
        $display("Test %s finished, %0d errors", name, errors - testStart);
        testStart = errors;
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic immediateTest();
        word_t       r;
        logic [11:0] imm;
        for (int i = 0; i < 9; i++) begin
            r = $random(seed);
            runAndCheck(iTypeWord(r[11:0], 5'd0, 3'd0, 5'd1));  // ADDI x1, x0, rand
            r   = $random(seed);
            imm = (immF3[i] == 3'd1 || immF3[i] == 3'd5) ? {(i == 8) ? 7'h20 : 7'h00, r[4:0]}
                                                        : r[11:0];
            runAndCheck(iTypeWord(imm, 5'd1, immF3[i], 5'd2));
        end
        endTest("immediate");
    endtask

    task automatic registerTest();
        word_t   r;
        regIdx_t rs1, rs2, rd;
        for (int k = 1; k < 8; k++) begin
            r = $random(seed);
            runAndCheck(iTypeWord(r[11:0], 5'd0, 3'd0, regIdx_t'(k)));
        end
        for (int i = 0; i < 10; i++) begin
            rs1 = regIdx_t'(1 + {$random(seed)} % 7);
            rs2 = regIdx_t'(1 + {$random(seed)} % 7);
            rd  = regIdx_t'(1 + {$random(seed)} % 7);
            runAndCheck(rTypeWord((i == 1 || i == 7) ? 7'h20 : 7'h00, rs2, rs1, regF3[i], rd));
        end
        // Dependent chain written back to back
        issue(rTypeWord(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
        issue(rTypeWord(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));
        issue(rTypeWord(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
        issue(rTypeWord(7'h20, 5'd2, 5'd5, 3'd5, 5'd6));
        waitIdle();
        compareResult();
        endTest("register");
    endtask

    task automatic branchTest();
        regIdx_t lhs [5] = '{5'd1, 5'd1, 5'd4, 5'd3, 5'd1};
        regIdx_t rhs [5] = '{5'd2, 5'd4, 5'd1, 5'd1, 5'd3};
        runAndCheck(iTypeWord(12'd5, 5'd0, 3'd0, 5'd1));
        runAndCheck(iTypeWord(12'd5, 5'd0, 3'd0, 5'd2));
        runAndCheck(iTypeWord(12'hFFD, 5'd0, 3'd0, 5'd3));  // -3 reads large as unsigned
        runAndCheck(iTypeWord(12'd7, 5'd0, 3'd0, 5'd4));
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 5; p++) begin
                issue(branchWord(13'd8, rhs[p], lhs[p], brF3[f]));
                waitIdle();
                compareBranch();
            end
        end
        endTest("branch");
    endtask

    task automatic backPressureTest();
        issue(iTypeWord(12'd1, 5'd0, 3'd0, 5'd5));
        for (int i = 0; i < QueueDepth + 4; i++) begin  // Order sensitive mix
            case (i % 3)
                0:       issue(iTypeWord(12'd1, 5'd5, 3'd1, 5'd5));
                1:       issue(iTypeWord(12'(i), 5'd5, 3'd4, 5'd5));
                default: issue(iTypeWord(12'(3 * i), 5'd5, 3'd0, 5'd5));
            endcase
        end
        waitIdle();
        compareResult();
        endTest("backpressure");
    endtask

    task automatic illegalTest();
        word_t data;
        logic  err;
        issue({12'h010, 5'd1, 3'd2, 5'd6, opLoad});  // LW x6, 16(x1)
        waitIdle();
        compareResult();
        apbRead(addrStatus, data, err);
        checkWord("illegalCount", word_t'(data[15:8]), word_t'(expIllegal));
        apbRead(addrBad, data, err);
        checkFlag("pslverr", err, 1'b1);
        // A legal ADDI that would show in RESULT if it reached the queue
        apbWrite(addrBad, iTypeWord(12'h123, 5'd0, 3'd0, 5'd7), err);
        checkFlag("pslverr", err, 1'b1);
        waitIdle();
        compareResult();
        endTest("illegal");
    endtask

    initial begin
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int k = 0; k < 32; k++) refReg[k] = '0;
        expResult      = '0;
        expTaken       = 1'b0;
        expBranchCount = '0;
        expIllegal     = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        checkFlag("pready", pready, 1'b1);
        immediateTest();
        registerTest();
        branchTest();
        backPressureTest();
        illegalTest();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rvExec.f */
rtl/rvExecPkg.sv
rtl/instrDecode.sv
rtl/alu.sv
rtl/execUnit.sv
rtl/instrQueue.sv
rtl/apbCmdPort.sv
rtl/rvExecTop.sv
bench/execUnit_assert.sv
bench/rvExecBench.sv
